/* opm_config.svh */
`ifndef OPM_CONFIG_SVH
`define OPM_CONFIG_SVH

// slot frame structure
`define OPM_SLOTS           32
`define OPM_TB_PRESCALE     16      // frames per timer b tick

// widths
`define OPM_D_W             8       // cpu data bus
`define OPM_TA_W            10
`define OPM_TB_W            8

// busy flag length after a data write, in clocks
`define OPM_BUSY_CYCLES     64

//////////////////////////////////////////////////////////////////////
// register map
`define OPM_REG_CLKA1       8'h10   // timer a bits 9..2
`define OPM_REG_CLKA2       8'h11   // timer a bits 1..0
`define OPM_REG_CLKB        8'h12
`define OPM_REG_TIMERCTRL   8'h14   // run, irq enable, flag reset
`define OPM_REG_CT          8'h1B   // ct2 in bit 7, ct1 in bit 6

`endif

/* opm_pkg.sv */
`include "opm_config.svh"

package opm_pkg;

//////////////////////////////////////////////////////////////////////
// slot timing strobes

typedef struct packed {
    logic frame;        // last slot of a frame
    logic prescaled;    // frame end of every 16th frame
} opm_tick_t;

//////////////////////////////////////////////////////////////////////
// timer control and status

typedef struct packed {
    logic run;          // counter enabled
    logic irq_en;       // overflow may set the flag
    logic frst;         // one-clock flag clear
} opm_timer_ctrl_t;

typedef struct packed {
    logic ovfl;         // one-clock overflow pulse
    logic flag;         // latched interrupt flag
} opm_timer_stat_t;

//////////////////////////////////////////////////////////////////////
// cpu bus pins, as sampled on i_emuclk

// control pins are active low like on the chip
typedef struct packed {
    logic                   cs_n;
    logic                   rd_n;
    logic                   wr_n;
    logic                   a0;     // 0 = address, 1 = data
    logic [`OPM_D_W-1:0]    data;
} opm_bus_t;

endpackage

/* opm_slot_timing.sv */
`timescale 1ns/1ns
`include "opm_config.svh"

module opm_slot_timing (
    input   logic                   i_emuclk,
    input   logic                   i_rst,
    output  opm_pkg::opm_tick_t     o_tick
);

localparam int SLOT_W  = $clog2(`OPM_SLOTS);
localparam int FRAME_W = $clog2(`OPM_TB_PRESCALE);

logic   [SLOT_W-1:0]    slot_cnt;   // one slot per clock
logic   [FRAME_W-1:0]   frame_cnt;  // frames since last prescaled tick
logic                   last_slot;
logic                   last_frame;

assign last_slot  = (slot_cnt == SLOT_W'(`OPM_SLOTS - 1));
assign last_frame = (frame_cnt == FRAME_W'(`OPM_TB_PRESCALE - 1));

always_ff @(posedge i_emuclk) begin
    if (i_rst) begin
        slot_cnt  <= '0;
        frame_cnt <= '0;
    end else begin
        slot_cnt <= last_slot ? '0 : slot_cnt + 1'b1;

        // frame counter moves once per frame
        if (last_slot) begin
            frame_cnt <= last_frame ? '0 : frame_cnt + 1'b1;
        end
    end
end

assign o_tick = '{
    frame:     last_slot,
    prescaled: last_slot & last_frame
};

//////////////////////////////////////////////////////////////////////
// checks

// timer b tick must line up with a frame end
a_prescaled_on_frame: assert property (
    @(posedge i_emuclk) disable iff (i_rst)
    o_tick.prescaled |-> o_tick.frame
) else $error("prescaled tick outside frame end");

endmodule

/* opm_timer.sv */
`timescale 1ns/1ns

module opm_timer #(
    parameter int CNT_W = 10
) (
    input   logic                       i_emuclk,
    input   logic                       i_rst,

    input   logic                       i_tick,     // count enable
    input   logic   [CNT_W-1:0]         i_load,     // reload value n

    input   opm_pkg::opm_timer_ctrl_t   i_ctrl,
    output  opm_pkg::opm_timer_stat_t   o_stat
);

logic   [CNT_W-1:0]     cnt;
logic                   run_d;      // run one clock ago
logic                   flag;
logic                   run_rise;
logic                   ovfl;

assign run_rise = i_ctrl.run & ~run_d;

// only a counter that was already running can overflow
assign ovfl = i_ctrl.run & run_d & i_tick & (&cnt);

//////////////////////////////////////////////////////////////////////
// counter

always_ff @(posedge i_emuclk) begin
    if (i_rst) begin
        run_d <= 1'b0;
    end else begin
        run_d <= i_ctrl.run;
    end
end

always_ff @(posedge i_emuclk) begin
    if (i_rst) begin
        cnt <= '0;
    end else if (run_rise) begin
        cnt <= i_load;                          // start from n
    end else if (i_ctrl.run && i_tick) begin
        cnt <= ovfl ? i_load : cnt + 1'b1;      // all ones wraps to n
    end
end

//////////////////////////////////////////////////////////////////////
// interrupt flag

always_ff @(posedge i_emuclk) begin
    if (i_rst) begin
        flag <= 1'b0;
    end else if (i_ctrl.frst) begin
        flag <= 1'b0;                           // clear beats set
    end else if (ovfl && i_ctrl.irq_en) begin
        flag <= 1'b1;
    end
end

assign o_stat = '{
    ovfl: ovfl,
    flag: flag
};

//////////////////////////////////////////////////////////////////////
// checks

// the load clock never overflows, so run must have been high a clock earlier too
a_ovfl_needs_run: assert property (
    @(posedge i_emuclk) disable iff (i_rst)
    o_stat.ovfl |-> (i_ctrl.run && $past(i_ctrl.run))
) else $error("timer overflow while not running");

endmodule

/* opm_bus_ctrl.sv */
`timescale 1ns/1ns
`include "opm_config.svh"

module opm_bus_ctrl (
    input   logic                       i_emuclk,
    input   logic                       i_rst,

    // cpu side
    input   opm_pkg::opm_bus_t          i_bus,

    // timers
    input   opm_pkg::opm_timer_stat_t   i_stat_a,
    input   opm_pkg::opm_timer_stat_t   i_stat_b,
    output  logic   [`OPM_TA_W-1:0]     o_load_a,
    output  logic   [`OPM_TB_W-1:0]     o_load_b,
    output  opm_pkg::opm_timer_ctrl_t   o_ctrl_a,
    output  opm_pkg::opm_timer_ctrl_t   o_ctrl_b,

    // read data
    output  logic   [`OPM_D_W-1:0]      o_d,
    output  logic                       o_d_oe,

    // pins
    output  logic                       o_irq_n,
    output  logic                       o_ct1,
    output  logic                       o_ct2
);

localparam int BUSY_W = $clog2(`OPM_BUSY_CYCLES + 1);

//////////////////////////////////////////////////////////////////////
// bus decode

logic                   wr;
logic                   rd;
logic                   addr_wr;
logic                   data_wr;

assign wr      = ~i_bus.cs_n & ~i_bus.wr_n;
assign rd      = ~i_bus.cs_n & ~i_bus.rd_n;
assign addr_wr = wr & ~i_bus.a0;
assign data_wr = wr &  i_bus.a0;

//////////////////////////////////////////////////////////////////////
// address latch and register file

logic   [`OPM_D_W-1:0]  addr_q;     // latched register address
logic   [7:0]           clka1;
logic   [1:0]           clka2;
logic   [7:0]           clkb;
logic                   run_a, run_b;
logic                   irq_en_a, irq_en_b;
logic                   frst_a, frst_b;
logic                   ct1, ct2;

always_ff @(posedge i_emuclk) begin
    if (i_rst) begin
        addr_q <= '0;
    end else if (addr_wr) begin
        addr_q <= i_bus.data;
    end
end

always_ff @(posedge i_emuclk) begin
    if (i_rst) begin
        clka1    <= '0;
        clka2    <= '0;
        clkb     <= '0;
        run_a    <= 1'b0;
        run_b    <= 1'b0;
        irq_en_a <= 1'b0;
        irq_en_b <= 1'b0;
        frst_a   <= 1'b0;
        frst_b   <= 1'b0;
        ct1      <= 1'b0;
        ct2      <= 1'b0;
    end else begin
        // flag resets are pulses, not stored
        frst_a <= 1'b0;
        frst_b <= 1'b0;

        if (data_wr) begin
            case (addr_q)
                `OPM_REG_CLKA1:     clka1 <= i_bus.data;
                `OPM_REG_CLKA2:     clka2 <= i_bus.data[1:0];
                `OPM_REG_CLKB:      clkb  <= i_bus.data;
                `OPM_REG_TIMERCTRL: begin
                    run_a    <= i_bus.data[0];
                    run_b    <= i_bus.data[1];
                    irq_en_a <= i_bus.data[2];
                    irq_en_b <= i_bus.data[3];
                    frst_a   <= i_bus.data[4];
                    frst_b   <= i_bus.data[5];
                end
                `OPM_REG_CT: begin
                    ct2 <= i_bus.data[7];
                    ct1 <= i_bus.data[6];
                end
                default: ;  // sound registers, not kept here
            endcase
        end
    end
end

assign o_load_a = {clka1, clka2};
assign o_load_b = clkb;

assign o_ctrl_a = '{run: run_a, irq_en: irq_en_a, frst: frst_a};
assign o_ctrl_b = '{run: run_b, irq_en: irq_en_b, frst: frst_b};

assign o_ct1 = ct1;
assign o_ct2 = ct2;

//////////////////////////////////////////////////////////////////////
// busy flag

logic   [BUSY_W-1:0]    busy_cnt;   // clocks of busy left
logic                   busy;

always_ff @(posedge i_emuclk) begin
    if (i_rst) begin
        busy_cnt <= '0;
    end else if (data_wr) begin
        busy_cnt <= BUSY_W'(`OPM_BUSY_CYCLES);  // restart on every data write
    end else if (busy_cnt != '0) begin
        busy_cnt <= busy_cnt - 1'b1;
    end
end

assign busy = (busy_cnt != '0);

//////////////////////////////////////////////////////////////////////
// status read and irq

logic   [`OPM_D_W-1:0]  status;

assign status = {busy, 5'b0_0000, i_stat_b.flag, i_stat_a.flag};

always_ff @(posedge i_emuclk) begin
    if (i_rst) begin
        o_d <= '0;
    end else if (rd) begin
        o_d <= status;      // follows status while the read is held
    end
end

always_ff @(posedge i_emuclk) begin
    if (i_rst) begin
        o_d_oe <= 1'b0;
    end else begin
        o_d_oe <= rd;
    end
end

assign o_irq_n = ~(i_stat_a.flag | i_stat_b.flag);

//////////////////////////////////////////////////////////////////////
// checks

// busy drops exactly OPM_BUSY_CYCLES clocks after the last data write
a_busy_len: assert property (
    @(posedge i_emuclk) disable iff (i_rst)
    $fell(busy) |-> $past(data_wr, `OPM_BUSY_CYCLES + 1)
) else $error("busy flag length wrong");

a_oe_after_read: assert property (
    @(posedge i_emuclk) disable iff (i_rst)
    !$past(rd) |-> !o_d_oe
) else $error("data output enabled without a read");

// a timer flag only sets from an enabled overflow
a_flag_a_src: assert property (
    @(posedge i_emuclk) disable iff (i_rst)
    $rose(i_stat_a.flag) |-> $past(i_stat_a.ovfl && o_ctrl_a.irq_en)
) else $error("timer a flag set without enabled overflow");

a_flag_b_src: assert property (
    @(posedge i_emuclk) disable iff (i_rst)
    $rose(i_stat_b.flag) |-> $past(i_stat_b.ovfl && o_ctrl_b.irq_en)
) else $error("timer b flag set without enabled overflow");

endmodule

/* opm_core.sv */
`timescale 1ns/1ns
`include "opm_config.svh"

module opm_core (
    input   logic                   i_emuclk,   // one slot per clock
    input   logic                   i_rst,

    // bus control and address
    input   logic                   i_cs_n,
    input   logic                   i_rd_n,
    input   logic                   i_wr_n,
    input   logic                   i_a0,

    // bus data
    input   logic   [7:0]           i_d,
    output  logic   [7:0]           o_d,
    output  logic                   o_d_oe,

    // pins
    output  logic                   o_irq_n,
    output  logic                   o_ct1,      // reg 0x1B bit 6
    output  logic                   o_ct2       // reg 0x1B bit 7
);

//////////////////////////////////////////////////////////////////////
// interconnects

opm_pkg::opm_bus_t          bus;
opm_pkg::opm_tick_t         tick;
opm_pkg::opm_timer_ctrl_t   ctrl_a, ctrl_b;
opm_pkg::opm_timer_stat_t   stat_a, stat_b;
logic   [`OPM_TA_W-1:0]     load_a;
logic   [`OPM_TB_W-1:0]     load_b;

assign bus = '{cs_n: i_cs_n, rd_n: i_rd_n, wr_n: i_wr_n, a0: i_a0, data: i_d};

//////////////////////////////////////////////////////////////////////
// modules

opm_slot_timing u_slot_timing (
    .i_emuclk   (i_emuclk   ),
    .i_rst      (i_rst      ),
    .o_tick     (tick       )
);

opm_bus_ctrl u_bus_ctrl (
    .i_emuclk   (i_emuclk   ),
    .i_rst      (i_rst      ),
    .i_bus      (bus        ),
    .i_stat_a   (stat_a     ),
    .i_stat_b   (stat_b     ),
    .o_load_a   (load_a     ),
    .o_load_b   (load_b     ),
    .o_ctrl_a   (ctrl_a     ),
    .o_ctrl_b   (ctrl_b     ),
    .o_d        (o_d        ),
    .o_d_oe     (o_d_oe     ),
    .o_irq_n    (o_irq_n    ),
    .o_ct1      (o_ct1      ),
    .o_ct2      (o_ct2      )
);

opm_timer #(.CNT_W(`OPM_TA_W)) u_timer_a (
    .i_emuclk   (i_emuclk   ),
    .i_rst      (i_rst      ),
    .i_tick     (tick.frame ),  // counts frames
    .i_load     (load_a     ),
    .i_ctrl     (ctrl_a     ),
    .o_stat     (stat_a     )
);

opm_timer #(.CNT_W(`OPM_TB_W)) u_timer_b (
    .i_emuclk   (i_emuclk       ),
    .i_rst      (i_rst          ),
    .i_tick     (tick.prescaled ),  // every 16th frame
    .i_load     (load_b         ),
    .i_ctrl     (ctrl_b         ),
    .o_stat     (stat_b         )
);

endmodule

/* tb_opm_tasks.svh */
`ifndef TB_OPM_TASKS_SVH
`define TB_OPM_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// bus access, all driven on the falling edge

task automatic bus_write(input logic a0, input logic [7:0] data);
    @(negedge clk);
    i_cs_n = 1'b0;
    i_wr_n = 1'b0;
    i_a0   = a0;        // 0 = address, 1 = data
    i_d    = data;
    @(negedge clk);
    i_cs_n = 1'b1;
    i_wr_n = 1'b1;
endtask

task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
    bus_write(1'b0, addr);
    bus_write(1'b1, data);
endtask

// one clock of read, then one idle clock to see o_d_oe drop
task automatic read_status(output logic [7:0] val, output logic oe_during,
                           output logic oe_after);
    @(negedge clk);
    i_cs_n = 1'b0;
    i_rd_n = 1'b0;
    @(negedge clk);
    val       = o_d;
    oe_during = o_d_oe;
    i_cs_n    = 1'b1;
    i_rd_n    = 1'b1;
    @(negedge clk);
    oe_after = o_d_oe;
endtask

//////////////////////////////////////////////////////////////////////
// waits and checks

task automatic wait_irq(input logic level, input int max_cycles, output int cycles,
                        output bit timed_out);
    cycles = 0;
    while (o_irq_n !== level && cycles < max_cycles) begin
        @(negedge clk);
        cycles++;
    end
    timed_out = (o_irq_n !== level);
endtask

task automatic check(input string name, input logic [31:0] expected,
                     input logic [31:0] actual);
    if (expected !== actual) begin
        $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        err_count++;
    end
endtask

`endif

/* tb_opm_core.sv */
`timescale 1ns/1ns
`include "opm_config.svh"

module tb_opm_core;

localparam int NUM_TESTS = 13;
localparam logic [2:0] K_RESET = 3'd0, K_REG = 3'd1, K_BUSY = 3'd2;
localparam logic [2:0] K_TIMER_A = 3'd3, K_TIMER_B = 3'd4, K_NO_IRQ = 3'd5;

typedef struct packed {
    logic [2:0]     kind;
    logic [7:0]     addr;
    logic [9:0]     value;      // data byte or timer n
    logic [31:0]    expected;
} entry_t;

logic           clk, i_rst, i_cs_n, i_rd_n, i_wr_n, i_a0;
logic   [7:0]   i_d, o_d;
logic           o_d_oe, o_irq_n, o_ct1, o_ct2;

entry_t tbl [NUM_TESTS];
string  names [NUM_TESTS];
integer seed;
int     err_count = 0;
int     pass_count = 0;
int     fail_count = 0;
int     n_entries = 0;
int     errs_before;

`include "tb_opm_tasks.svh"

opm_core uut (
    .i_emuclk   (clk    ),
    .i_rst      (i_rst  ),
    .i_cs_n     (i_cs_n ),
    .i_rd_n     (i_rd_n ),
    .i_wr_n     (i_wr_n ),
    .i_a0       (i_a0   ),
    .i_d        (i_d    ),
    .o_d        (o_d    ),
    .o_d_oe     (o_d_oe ),
    .o_irq_n    (o_irq_n),
    .o_ct1      (o_ct1  ),
    .o_ct2      (o_ct2  )
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

//////////////////////////////////////////////////////////////////////
// stimulus table

task automatic add_entry(input string name, input logic [2:0] kind, input logic [7:0] addr,
                         input logic [9:0] value, input logic [31:0] expected);
    names[n_entries] = name;
    tbl[n_entries]   = '{kind: kind, addr: addr, value: value, expected: expected};
    n_entries++;
endtask

task automatic fill_table();
    int rnd_n;
    rnd_n = 1000 + ($unsigned($random(seed)) % 24);
    add_entry("reset_state", K_RESET, 8'h00, 10'h000, 32'h0);
    add_entry("ct2_set",     K_REG, `OPM_REG_CT, 10'h080, 32'd2);   // {ct2, ct1}
    add_entry("ct1_set",     K_REG, `OPM_REG_CT, 10'h040, 32'd1);
    add_entry("ct_both",     K_REG, `OPM_REG_CT, 10'h0C0, 32'd3);
    add_entry("unused_1c",   K_REG, 8'h1C,       10'h03F, 32'd3);   // pins hold
    add_entry("unused_13",   K_REG, 8'h13,       10'h000, 32'd3);
    add_entry("ct_clear",    K_REG, `OPM_REG_CT, 10'h000, 32'd0);
    add_entry("busy_flag",   K_BUSY, `OPM_REG_CT, 10'h000, 32'h80);
    add_entry("timer_a_1000", K_TIMER_A, 8'h00, 10'd1000, (1024 - 1000) * `OPM_SLOTS);
    add_entry("timer_a_1023", K_TIMER_A, 8'h00, 10'd1023, (1024 - 1023) * `OPM_SLOTS);
    add_entry("timer_b_254", K_TIMER_B, 8'h00, 10'd254,
              (256 - 254) * `OPM_SLOTS * `OPM_TB_PRESCALE);
    add_entry("timer_b_250", K_TIMER_B, 8'h00, 10'd250,
              (256 - 250) * `OPM_SLOTS * `OPM_TB_PRESCALE);
    add_entry("timer_a_no_irq", K_NO_IRQ, 8'h00, 10'(rnd_n), 32'h0);
endtask

//////////////////////////////////////////////////////////////////////
// test bodies

task automatic load_timer_a(input logic [9:0] n);
    write_reg(`OPM_REG_CLKA1, n[9:2]);
    write_reg(`OPM_REG_CLKA2, {6'b0, n[1:0]});
endtask

task automatic test_timer(input int i, input bit is_b);
    int         tol;
    int         cycles;
    int         diff;
    bit         to;
    logic [7:0] st;
    logic       oe_d, oe_a;
    tol = is_b ? `OPM_SLOTS * `OPM_TB_PRESCALE : `OPM_SLOTS;
    if (is_b) begin
        write_reg(`OPM_REG_CLKB, tbl[i].value[7:0]);
        write_reg(`OPM_REG_TIMERCTRL, 8'h0A);   // run b, irq b
    end else begin
        load_timer_a(tbl[i].value);
        write_reg(`OPM_REG_TIMERCTRL, 8'h05);
    end
    wait_irq(1'b0, int'(tbl[i].expected) + 2 * tol, cycles, to);
    if (to) begin
        $display("%s: o_irq_n never fell", names[i]);
        err_count++;
    end else begin
        diff = cycles - int'(tbl[i].expected);
        if (diff < 0) begin
            diff = -diff;
        end
        check({names[i], " period"}, tbl[i].expected,
              (diff <= tol) ? tbl[i].expected : 32'(cycles));
    end
    read_status(st, oe_d, oe_a);
    check({names[i], " flag"}, is_b ? 32'h2 : 32'h1, {24'h0, st & 8'h03});
    write_reg(`OPM_REG_TIMERCTRL, is_b ? 8'h20 : 8'h10);   // frst, timer stops
    wait_irq(1'b1, 2, cycles, to);
    if (to) begin
        $display("%s: o_irq_n still low two clocks after the flag reset", names[i]);
        err_count++;
    end
endtask

task automatic test_no_irq(input int i);
    int         span;
    bit         low_seen;
    logic [7:0] st;
    logic       oe_d, oe_a;
    span     = 2 * (1024 - int'(tbl[i].value)) * `OPM_SLOTS;
    low_seen = 1'b0;
    load_timer_a(tbl[i].value);
    write_reg(`OPM_REG_TIMERCTRL, 8'h01);   // run only
    repeat (span) begin
        @(negedge clk);
        if (!o_irq_n) low_seen = 1'b1;
    end
    check({names[i], " irq_n"}, 32'h1, {31'h0, ~low_seen});
    read_status(st, oe_d, oe_a);
    check({names[i], " flag"}, tbl[i].expected, {31'h0, st[0]});
    write_reg(`OPM_REG_TIMERCTRL, 8'h00);
endtask

task automatic run_test(input int i);
    logic [7:0] st;
    logic       oe_d, oe_a;
    case (tbl[i].kind)
        K_RESET: begin
            check({names[i], " irq_n"}, 32'h1, {31'h0, o_irq_n});
            check({names[i], " ct"}, 32'h0, {30'h0, o_ct2, o_ct1});
            check({names[i], " oe"}, 32'h0, {31'h0, o_d_oe});
            read_status(st, oe_d, oe_a);
            check({names[i], " status"}, tbl[i].expected, {24'h0, st});
        end
        K_REG: begin
            write_reg(tbl[i].addr, tbl[i].value[7:0]);
            check(names[i], tbl[i].expected, {30'h0, o_ct2, o_ct1});
        end
        K_BUSY: begin
            write_reg(tbl[i].addr, tbl[i].value[7:0]);
            read_status(st, oe_d, oe_a);
            check({names[i], " set"}, tbl[i].expected, {24'h0, st & 8'h80});
            check({names[i], " oe read"}, 32'h1, {31'h0, oe_d});
            check({names[i], " oe idle"}, 32'h0, {31'h0, oe_a});
            repeat (`OPM_BUSY_CYCLES + 4) @(negedge clk);
            read_status(st, oe_d, oe_a);
            check({names[i], " clear"}, 32'h0, {24'h0, st & 8'h80});
        end
        K_TIMER_A: test_timer(i, 1'b0);
        K_TIMER_B: test_timer(i, 1'b1);
        default:   test_no_irq(i);
    endcase
endtask

//////////////////////////////////////////////////////////////////////
// main sequence

initial begin
    i_rst  = 1'b1;
    i_cs_n = 1'b1;
    i_rd_n = 1'b1;
    i_wr_n = 1'b1;
    i_a0   = 1'b0;
    i_d    = 8'h00;
    seed   = 74617;
    fill_table();
    repeat (10) @(negedge clk);
    i_rst = 1'b0;

    for (int i = 0; i < NUM_TESTS; i++) begin
        errs_before = err_count;
        run_test(i);
        if (err_count == errs_before) begin
            pass_count++;
            $display("test %s: pass", names[i]);
        end else begin
            fail_count++;
            $display("test %s: fail", names[i]);
        end
    end

    $display("tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
        $display("*** TEST PASSED ***");
    end else begin
        $display("*** TEST FAILED ***");
    end
    $finish;
end

endmodule

/* project.f */
+incdir+.
opm_pkg.sv
opm_slot_timing.sv
opm_timer.sv
opm_bus_ctrl.sv
opm_core.sv
tb_opm_core.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_opm_core \
    -f project.f -o tb_opm_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_opm_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' "$LOG"; then
    exit 0
fi
exit 1
